//--- all.f
logic/bus_pkg.sv
logic/mem_pkg.sv
logic/lsu_core.sv
logic/bus_xbar.sv
logic/sram_slave.sv
logic/uart_slave.sv
logic/lsu_top.sv
bench/lsu_sva.sv
bench/lsu_tb.sv

//--- Makefile
TOP = lsu_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f all.f -o lsu_sim

run: compile
	@out="$$(./obj_dir/lsu_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

//--- bench/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;
    import bus_pkg::*;
    import mem_pkg::*;

    typedef struct packed {
        mem_op_e     op;
        mem_size_e   size;
        logic        sign;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_rdata;
        logic        exp_err;
        logic        tx_en;
        logic [7:0]  tx_byte;
    } vec_t;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    lsu_req_t    req;
    logic        req_ready;
    logic        rsp_valid;
    lsu_rsp_t    rsp;
    logic        tx_valid;
    logic [7:0]  tx_byte;

    vec_t        vectors[$];
    logic [31:0] model [SRAM_WORDS];   // copy of the sram for the sweep
    bit          touched [SRAM_WORDS];
    int          errors = 0;
    int          fails = 0;
    int          tests = 0;
    int          tx_count = 0;
    logic [7:0]  tx_last;
    bit          timed_out = 1'b0;

    lsu_top lsu_top_inst (.*);

    always #10 clk = ~clk;

    // tx pulses seen mid-cycle
    always @(negedge clk) begin
        if (tx_valid) begin
            tx_count <= tx_count + 1;
            tx_last  <= tx_byte;
        end
    end

    function automatic vec_t make_vec(input mem_op_e op, input mem_size_e size,
                                      input logic sign, input logic [31:0] addr,
                                      input logic [31:0] wdata, input logic [31:0] exp_rdata,
                                      input logic exp_err, input logic [8:0] tx);
        vec_t v;
        v.op        = op;
        v.size      = size;
        v.sign      = sign;
        v.addr      = addr;
        v.wdata     = wdata;
        v.exp_rdata = exp_rdata;
        v.exp_err   = exp_err;
        v.tx_en     = tx[8];   // flag above the byte
        v.tx_byte   = tx[7:0];
        return v;
    endfunction

    function automatic void add_row(input mem_op_e op, input mem_size_e size,
                                    input logic sign, input logic [31:0] addr,
                                    input logic [31:0] wdata, input logic [31:0] exp_rdata,
                                    input logic exp_err, input logic [8:0] tx);
        vectors.push_back(make_vec(op, size, sign, addr, wdata, exp_rdata, exp_err, tx));
    endfunction

    function automatic void fill_table();
        // sram word then merged byte and half lanes
        add_row(op_store, size_word, 1'b0, 32'h80000010, 32'h12345678, 32'h0, 1'b0, 9'h000);
        add_row(op_load,  size_word, 1'b0, 32'h80000010, 32'h0, 32'h12345678, 1'b0, 9'h000);
        add_row(op_store, size_byte, 1'b0, 32'h80000020, 32'h000000a1, 32'h0, 1'b0, 9'h000);
        add_row(op_store, size_byte, 1'b0, 32'h80000021, 32'h12345682, 32'h0, 1'b0, 9'h000);
        add_row(op_store, size_half, 1'b0, 32'h80000022, 32'h0000f3c4, 32'h0, 1'b0, 9'h000);
        add_row(op_load,  size_word, 1'b0, 32'h80000020, 32'h0, 32'hf3c482a1, 1'b0, 9'h000);
        add_row(op_load,  size_byte, 1'b1, 32'h80000021, 32'h0, 32'hffffff82, 1'b0, 9'h000);
        add_row(op_load,  size_byte, 1'b0, 32'h80000021, 32'h0, 32'h00000082, 1'b0, 9'h000);
        add_row(op_load,  size_byte, 1'b1, 32'h80000020, 32'h0, 32'hffffffa1, 1'b0, 9'h000);
        add_row(op_load,  size_half, 1'b1, 32'h80000022, 32'h0, 32'hfffff3c4, 1'b0, 9'h000);
        add_row(op_load,  size_half, 1'b0, 32'h80000022, 32'h0, 32'h0000f3c4, 1'b0, 9'h000);
        add_row(op_load,  size_half, 1'b1, 32'h80000020, 32'h0, 32'hffff82a1, 1'b0, 9'h000);
        add_row(op_store, size_byte, 1'b0, 32'h80000023, 32'h00000011, 32'h0, 1'b0, 9'h000);
        add_row(op_load,  size_byte, 1'b1, 32'h80000023, 32'h0, 32'h00000011, 1'b0, 9'h000);
        add_row(op_load,  size_byte, 1'b1, 32'h80000022, 32'h0, 32'hffffffc4, 1'b0, 9'h000);
        add_row(op_load,  size_word, 1'b0, 32'h80000020, 32'h0, 32'h11c482a1, 1'b0, 9'h000);
        // low half and lane 2 byte over the same word
        add_row(op_store, size_half, 1'b0, 32'h80000020, 32'hffff7e35, 32'h0, 1'b0, 9'h000);
        add_row(op_store, size_byte, 1'b0, 32'h80000022, 32'h0000005a, 32'h0, 1'b0, 9'h000);
        add_row(op_load,  size_word, 1'b0, 32'h80000020, 32'h0, 32'h115a7e35, 1'b0, 9'h000);
        // serial port
        add_row(op_store, size_byte, 1'b0, 32'ha00003f8, 32'h00000048, 32'h0, 1'b0, 9'h148);
        add_row(op_store, size_byte, 1'b0, 32'ha00003f8, 32'h00000069, 32'h0, 1'b0, 9'h169);
        add_row(op_store, size_word, 1'b0, 32'ha00003fc, 32'h00000055, 32'h0, 1'b0, 9'h000);
        add_row(op_load,  size_word, 1'b0, 32'ha00003fc, 32'h0, 32'h00000002, 1'b0, 9'h000);
        add_row(op_load,  size_word, 1'b0, 32'ha00003f8, 32'h0, 32'h00000000, 1'b0, 9'h000);
        // unmapped, then sram untouched
        add_row(op_load,  size_word, 1'b0, 32'h40000000, 32'h0, 32'h00000000, 1'b1, 9'h000);
        add_row(op_store, size_word, 1'b0, 32'h40000000, 32'hdeadbeef, 32'h0, 1'b1, 9'h000);
        add_row(op_load,  size_word, 1'b0, 32'h80001000, 32'h0, 32'h00000000, 1'b1, 9'h000);
        add_row(op_load,  size_word, 1'b0, 32'ha0000400, 32'h0, 32'h00000000, 1'b1, 9'h000);
        add_row(op_load,  size_word, 1'b0, 32'h80000010, 32'h0, 32'h12345678, 1'b0, 9'h000);
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // one request through the handshake, called 1 ns after an edge
    task automatic issue(input vec_t v, output lsu_rsp_t got, output bit ok);
        int n;
        ok  = 1'b0;
        got = '0;
        n   = 0;
        while (!req_ready && n < 200) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!req_ready) begin
            $display("timeout at %0t: req_ready never rose", $time);
            return;
        end
        req_valid = 1'b1;
        req       = '{op: v.op, size: v.size, sign: v.sign, addr: v.addr, wdata: v.wdata};
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        n = 0;
        while (!rsp_valid && n < 200) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!rsp_valid) begin
            $display("timeout at %0t: no rsp_valid after the request", $time);
            return;
        end
        got = rsp;
        ok  = 1'b1;
    endtask

    task automatic apply_vector(input vec_t v);
        lsu_rsp_t got;
        bit       ok;
        int       err_before;
        int       tx_before;
        err_before = errors;
        tx_before  = tx_count;
        tests++;
        issue(v, got, ok);
        if (!ok) begin
            timed_out = 1'b1;
            fails++;
            $display("test %0d: %s at %h got no response", tests, v.op.name(), v.addr);
            return;
        end
        check_value("rdata", got.rdata, v.exp_rdata);
        check_value("err", {31'd0, got.err}, {31'd0, v.exp_err});
        check_value("tx pulses", 32'(tx_count - tx_before), {31'd0, v.tx_en});
        if (v.tx_en) check_value("tx byte", {24'd0, tx_last}, {24'd0, v.tx_byte});
        if (errors != err_before) fails++;
        $display("test %0d: %s %s at %h %s", tests, v.op.name(), v.size.name(), v.addr,
                 (errors == err_before) ? "ok" : "mismatch");
    endtask

    initial begin
        int unsigned seed_ret;
        int          idx;
        int          err_before;
        logic [31:0] data;
        seed_ret  = $urandom(32'hbf84_3cfe);
        clk       = 1'b0;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        fill_table();

        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        err_before = errors;
        tests++;
        check_value("req_ready after reset", {31'd0, req_ready}, 32'd1);
        check_value("rsp_valid after reset", {31'd0, rsp_valid}, 32'd0);
        check_value("tx_valid after reset", {31'd0, tx_valid}, 32'd0);
        if (errors != err_before) fails++;
        $display("test %0d: reset state %s", tests, (errors == err_before) ? "ok" : "mismatch");

        for (int i = 0; i < vectors.size() && !timed_out; i++) begin
            apply_vector(vectors[i]);
        end

        // random word sweep over the sram
        for (int i = 0; i < 32 && !timed_out; i++) begin
            idx          = $urandom_range(SRAM_WORDS - 1, 0);
            data         = $urandom;
            model[idx]   = data;
            touched[idx] = 1'b1;
            apply_vector(make_vec(op_store, size_word, 1'b0, SRAM_BASE + 32'(idx) * 4,
                                  data, 32'h0, 1'b0, 9'h000));
        end
        for (int i = 0; i < SRAM_WORDS && !timed_out; i++) begin
            if (touched[i]) begin
                apply_vector(make_vec(op_load, size_word, 1'b0, SRAM_BASE + 32'(i) * 4,
                                      32'h0, model[i], 1'b0, 9'h000));
            end
        end

        $display("%0d tests, %0d failed, %0d mismatches", tests, fails, errors);
        if (errors == 0 && fails == 0 && !timed_out) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- bench/lsu_sva.sv
`timescale 1ns/1ps

module lsu_sva (
    input logic              clk,
    input logic              rst_n,
    input logic              req_valid,
    input logic              req_ready,
    input logic              rsp_valid,
    input logic              arvalid,
    input logic              arready,
    input bus_pkg::ar_chan_t ar,
    input logic              awvalid,
    input logic              awready,
    input bus_pkg::aw_chan_t aw,
    input logic              wvalid,
    input logic              wready,
    input bus_pkg::w_chan_t  w
);
    logic busy;   // accepted, no response yet

    always_ff @(posedge clk) begin
        if (!rst_n) busy <= 1'b0;
        else if (req_valid && req_ready) busy <= 1'b1;
        else if (rsp_valid) busy <= 1'b0;
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(ar))
        else $error("ar channel dropped or changed before arready");

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(aw))
        else $error("aw channel dropped or changed before awready");

    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(w))
        else $error("w channel dropped or changed before wready");

    rsp_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |=> !rsp_valid)
        else $error("rsp_valid high for two cycles");

    no_accept_busy: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> !req_ready)
        else $error("req_ready high while a request is in flight");

endmodule

bind lsu_core lsu_sva lsu_sva_inst (
    .clk(clk),
    .rst_n(rst_n),
    .req_valid(req_valid),
    .req_ready(req_ready),
    .rsp_valid(rsp_valid),
    .arvalid(arvalid),
    .arready(arready),
    .ar(ar),
    .awvalid(awvalid),
    .awready(awready),
    .aw(aw),
    .wvalid(wvalid),
    .wready(wready),
    .w(w)
);

//--- logic/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  mem_pkg::lsu_req_t req,
    output logic              req_ready,
    output logic              rsp_valid,
    output mem_pkg::lsu_rsp_t rsp,
    output logic              tx_valid,
    output logic [7:0]        tx_byte
);
    import bus_pkg::*;

    // core to crossbar
    logic     arvalid, arready, rvalid, rready, awvalid, awready, wvalid, wready, bvalid, bready;
    ar_chan_t ar;
    r_chan_t  r;
    aw_chan_t aw;
    w_chan_t  w;
    b_chan_t  b;

    // crossbar to slaves
    logic     arvalid_sram, arready_sram, rvalid_sram, rready_sram, awvalid_sram,
              awready_sram, wvalid_sram, wready_sram, bvalid_sram, bready_sram;
    logic     arvalid_uart, arready_uart, rvalid_uart, rready_uart, awvalid_uart,
              awready_uart, wvalid_uart, wready_uart, bvalid_uart, bready_uart;
    ar_chan_t ar_sram, ar_uart;
    r_chan_t  r_sram, r_uart;
    aw_chan_t aw_sram, aw_uart;
    w_chan_t  w_sram, w_uart;
    b_chan_t  b_sram, b_uart;

    lsu_core lsu_core_inst (.*);

    bus_xbar bus_xbar_inst (.*);

    sram_slave sram_slave_inst (
        .clk, .rst_n,
        .arvalid(arvalid_sram), .arready(arready_sram), .ar(ar_sram),
        .rvalid(rvalid_sram), .rready(rready_sram), .r(r_sram),
        .awvalid(awvalid_sram), .awready(awready_sram), .aw(aw_sram),
        .wvalid(wvalid_sram), .wready(wready_sram), .w(w_sram),
        .bvalid(bvalid_sram), .bready(bready_sram), .b(b_sram)
    );

    uart_slave uart_slave_inst (
        .clk, .rst_n,
        .arvalid(arvalid_uart), .arready(arready_uart), .ar(ar_uart),
        .rvalid(rvalid_uart), .rready(rready_uart), .r(r_uart),
        .awvalid(awvalid_uart), .awready(awready_uart), .aw(aw_uart),
        .wvalid(wvalid_uart), .wready(wready_uart), .w(w_uart),
        .bvalid(bvalid_uart), .bready(bready_uart), .b(b_uart),
        .tx_valid, .tx_byte
    );

endmodule

//--- logic/uart_slave.sv
`timescale 1ns/1ps

module uart_slave (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              arvalid, rready, awvalid, wvalid, bready,
    output logic              arready, rvalid, awready, wready, bvalid,
    input  bus_pkg::ar_chan_t ar,
    output bus_pkg::r_chan_t  r,
    input  bus_pkg::aw_chan_t aw,
    input  bus_pkg::w_chan_t  w,
    output bus_pkg::b_chan_t  b,
    output logic              tx_valid,
    output logic [7:0]        tx_byte
);
    import bus_pkg::*;

    logic [31:0] rdata_q;
    logic [31:0] sent_cnt;
    logic        w_pend;
    logic        wr_off4;   // write went to the counter offset
    logic        tx_fire;
    logic [7:0]  lane_byte;

    assign wready  = w_pend;
    assign tx_fire = wvalid && wready && !wr_off4;
    assign r       = '{data: rdata_q, resp: resp_okay};
    assign b       = '{resp: resp_okay};

    // lowest strobed lane carries the byte
    always_comb begin
        lane_byte = 8'h00;
        for (int i = 3; i >= 0; i--) begin
            if (w.strb[i]) lane_byte = w.data[8*i +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            awready  <= 1'b0;
            w_pend   <= 1'b0;
            bvalid   <= 1'b0;
            tx_valid <= 1'b0;
            sent_cnt <= 32'd0;
        end else begin
            arready  <= arvalid && !arready && !rvalid;
            awready  <= awvalid && !awready && !w_pend && !bvalid;
            tx_valid <= tx_fire;

            if (arvalid && arready) rvalid <= 1'b1;
            else if (rvalid && rready) rvalid <= 1'b0;

            if (awvalid && awready) w_pend <= 1'b1;
            else if (wvalid && wready) w_pend <= 1'b0;

            if (wvalid && wready) bvalid <= 1'b1;
            else if (bvalid && bready) bvalid <= 1'b0;

            if (tx_fire) sent_cnt <= sent_cnt + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) rdata_q <= ar.addr[2] ? sent_cnt : 32'd0;
        if (awvalid && awready) wr_off4 <= aw.addr[2];
        if (tx_fire) tx_byte <= lane_byte;
    end

endmodule

//--- logic/sram_slave.sv
`timescale 1ns/1ps

module sram_slave (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              arvalid, rready, awvalid, wvalid, bready,
    output logic              arready, rvalid, awready, wready, bvalid,
    input  bus_pkg::ar_chan_t ar,
    output bus_pkg::r_chan_t  r,
    input  bus_pkg::aw_chan_t aw,
    input  bus_pkg::w_chan_t  w,
    output bus_pkg::b_chan_t  b
);
    import bus_pkg::*;
    import mem_pkg::*;

    logic [31:0]                   mem [SRAM_WORDS];
    logic [31:0]                   rdata_q;
    logic [$clog2(SRAM_WORDS)-1:0] rd_idx;
    logic [$clog2(SRAM_WORDS)-1:0] wr_idx;
    logic [$clog2(SRAM_WORDS)-1:0] widx_q;
    logic                          w_pend;   // aw taken, waiting for w

    // word index wraps at the array depth
    assign rd_idx = ar.addr[$clog2(SRAM_WORDS)+1:2];
    assign wr_idx = aw.addr[$clog2(SRAM_WORDS)+1:2];

    assign wready = w_pend;
    assign r      = '{data: rdata_q, resp: resp_okay};
    assign b      = '{resp: resp_okay};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            awready <= 1'b0;
            w_pend  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            awready <= awvalid && !awready && !w_pend && !bvalid;

            if (arvalid && arready) rvalid <= 1'b1;
            else if (rvalid && rready) rvalid <= 1'b0;

            if (awvalid && awready) w_pend <= 1'b1;
            else if (wvalid && wready) w_pend <= 1'b0;

            if (wvalid && wready) bvalid <= 1'b1;
            else if (bvalid && bready) bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rdata_q <= mem[rd_idx];
        end
        if (awvalid && awready) begin
            widx_q <= wr_idx;
        end
        if (wvalid && wready) begin
            for (int i = 0; i < 4; i++) begin
                if (w.strb[i]) mem[widx_q][8*i +: 8] <= w.data[8*i +: 8];
            end
        end
    end

endmodule

//--- logic/bus_xbar.sv
`timescale 1ns/1ps

module bus_xbar (
    input  logic              clk,
    input  logic              rst_n,
    // upstream, from the lsu
    input  logic              arvalid, rready, awvalid, wvalid, bready,
    output logic              arready, rvalid, awready, wready, bvalid,
    input  bus_pkg::ar_chan_t ar,
    output bus_pkg::r_chan_t  r,
    input  bus_pkg::aw_chan_t aw,
    input  bus_pkg::w_chan_t  w,
    output bus_pkg::b_chan_t  b,
    // sram side
    output logic              arvalid_sram, rready_sram, awvalid_sram, wvalid_sram, bready_sram,
    input  logic              arready_sram, rvalid_sram, awready_sram, wready_sram, bvalid_sram,
    output bus_pkg::ar_chan_t ar_sram,
    input  bus_pkg::r_chan_t  r_sram,
    output bus_pkg::aw_chan_t aw_sram,
    output bus_pkg::w_chan_t  w_sram,
    input  bus_pkg::b_chan_t  b_sram,
    // uart side
    output logic              arvalid_uart, rready_uart, awvalid_uart, wvalid_uart, bready_uart,
    input  logic              arready_uart, rvalid_uart, awready_uart, wready_uart, bvalid_uart,
    output bus_pkg::ar_chan_t ar_uart,
    input  bus_pkg::r_chan_t  r_uart,
    output bus_pkg::aw_chan_t aw_uart,
    output bus_pkg::w_chan_t  w_uart,
    input  bus_pkg::b_chan_t  b_uart
);
    import bus_pkg::*;

    typedef enum logic [1:0] {tgt_none, tgt_sram, tgt_uart} tgt_e;
    typedef enum logic [1:0] {err_idle, err_rdata, err_wdata, err_wresp} err_e;

    tgt_e ar_tgt;
    tgt_e aw_tgt;
    tgt_e tgt_q;   // target of the access in flight
    err_e err_state;

    function automatic tgt_e decode(input logic [31:0] addr);
        if ((addr - SRAM_BASE) < SRAM_BYTES) return tgt_sram;
        if ((addr - UART_BASE) < UART_BYTES) return tgt_uart;
        return tgt_none;
    endfunction

    assign ar_tgt = decode(ar.addr);
    assign aw_tgt = decode(aw.addr);

    // address beats follow the live decode
    assign ar_sram      = ar;
    assign ar_uart      = ar;
    assign aw_sram      = aw;
    assign aw_uart      = aw;
    assign arvalid_sram = arvalid && ar_tgt == tgt_sram;
    assign arvalid_uart = arvalid && ar_tgt == tgt_uart;
    assign awvalid_sram = awvalid && aw_tgt == tgt_sram;
    assign awvalid_uart = awvalid && aw_tgt == tgt_uart;

    always_comb begin
        case (ar_tgt)
            tgt_sram: arready = arready_sram;
            tgt_uart: arready = arready_uart;
            default:  arready = (err_state == err_idle);
        endcase
        case (aw_tgt)
            tgt_sram: awready = awready_sram;
            tgt_uart: awready = awready_uart;
            default:  awready = (err_state == err_idle);
        endcase
    end

    // data and responses follow the latched target
    assign w_sram      = w;
    assign w_uart      = w;
    assign wvalid_sram = wvalid && tgt_q == tgt_sram;
    assign wvalid_uart = wvalid && tgt_q == tgt_uart;
    assign rready_sram = rready && tgt_q == tgt_sram;
    assign rready_uart = rready && tgt_q == tgt_uart;
    assign bready_sram = bready && tgt_q == tgt_sram;
    assign bready_uart = bready && tgt_q == tgt_uart;

    always_comb begin
        case (tgt_q)
            tgt_sram: begin
                rvalid = rvalid_sram;
                r      = r_sram;
                wready = wready_sram;
                bvalid = bvalid_sram;
                b      = b_sram;
            end
            tgt_uart: begin
                rvalid = rvalid_uart;
                r      = r_uart;
                wready = wready_uart;
                bvalid = bvalid_uart;
                b      = b_uart;
            end
            default: begin   // unmapped, answered locally
                rvalid = (err_state == err_rdata);
                r      = '{data: 32'd0, resp: resp_decerr};
                wready = (err_state == err_wdata);
                bvalid = (err_state == err_wresp);
                b      = '{resp: resp_decerr};
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tgt_q     <= tgt_none;
            err_state <= err_idle;
        end else begin
            if (arvalid && arready) tgt_q <= ar_tgt;
            if (awvalid && awready) tgt_q <= aw_tgt;
            case (err_state)
                err_idle: begin
                    if (arvalid && arready && ar_tgt == tgt_none) err_state <= err_rdata;
                    if (awvalid && awready && aw_tgt == tgt_none) err_state <= err_wdata;
                end
                err_rdata: if (rvalid && rready) err_state <= err_idle;
                err_wdata: if (wvalid && wready) err_state <= err_wresp;
                default:   if (bvalid && bready) err_state <= err_idle;
            endcase
        end
    end

endmodule

//--- logic/lsu_core.sv
`timescale 1ns/1ps

module lsu_core (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  mem_pkg::lsu_req_t req,
    output logic              req_ready,
    output logic              rsp_valid,
    output mem_pkg::lsu_rsp_t rsp,
    output logic              arvalid,
    input  logic              arready,
    output bus_pkg::ar_chan_t ar,
    input  logic              rvalid,
    output logic              rready,
    input  bus_pkg::r_chan_t  r,
    output logic              awvalid,
    input  logic              awready,
    output bus_pkg::aw_chan_t aw,
    output logic              wvalid,
    input  logic              wready,
    output bus_pkg::w_chan_t  w,
    input  logic              bvalid,
    output logic              bready,
    input  bus_pkg::b_chan_t  b
);
    import bus_pkg::*;
    import mem_pkg::*;

    typedef enum logic [2:0] {
        idle,
        rd_addr,
        rd_data,
        wr_addr,
        wr_data,
        wr_resp,
        done
    } state_e;

    state_e      state;
    lsu_req_t    req_q;
    lsu_rsp_t    rsp_q;
    logic [4:0]  lane_shift;
    logic [3:0]  strb;
    logic [31:0] rd_shifted;
    logic [31:0] rd_ext;

    assign lane_shift = {req_q.addr[1:0], 3'b000};   // byte offset in bits

    always_comb begin
        case (req_q.size)
            size_byte: strb = 4'b0001 << req_q.addr[1:0];
            size_half: strb = req_q.addr[1] ? 4'b1100 : 4'b0011;
            default:   strb = 4'b1111;
        endcase
    end

    // load path: bring the addressed lane down, then extend
    assign rd_shifted = r.data >> lane_shift;

    always_comb begin
        case (req_q.size)
            size_byte: rd_ext = {{24{req_q.sign & rd_shifted[7]}}, rd_shifted[7:0]};
            size_half: rd_ext = {{16{req_q.sign & rd_shifted[15]}}, rd_shifted[15:0]};
            default:   rd_ext = rd_shifted;
        endcase
    end

    assign req_ready = (state == idle);
    assign rsp_valid = (state == done);
    assign rsp       = rsp_q;

    assign arvalid = (state == rd_addr);
    assign ar      = '{addr: req_q.addr};
    assign rready  = (state == rd_data);
    assign awvalid = (state == wr_addr);
    assign aw      = '{addr: req_q.addr};
    assign wvalid  = (state == wr_data);
    assign w       = '{data: req_q.wdata << lane_shift, strb: strb};
    assign bready  = (state == wr_resp);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (req_valid) begin
                        state <= (req.op == op_load) ? rd_addr : wr_addr;
                    end
                end
                rd_addr: if (arready) state <= rd_data;
                rd_data: if (rvalid) state <= done;
                wr_addr: if (awready) state <= wr_data;
                wr_data: if (wready) state <= wr_resp;
                wr_resp: if (bvalid) state <= done;
                default: state <= idle;   // done lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q <= req;
        end
        if (rvalid && rready) begin
            rsp_q.rdata <= (r.resp == resp_decerr) ? 32'd0 : rd_ext;
            rsp_q.err   <= (r.resp == resp_decerr);
        end
        if (bvalid && bready) begin
            rsp_q.rdata <= 32'd0;   // stores return nothing
            rsp_q.err   <= (b.resp == resp_decerr);
        end
    end

endmodule

//--- logic/mem_pkg.sv
package mem_pkg;

    typedef enum logic {
        op_load,
        op_store
    } mem_op_e;

    // same codes as the pipeline's mask field
    typedef enum logic [1:0] {
        size_byte = 2'b01,
        size_half = 2'b10,
        size_word = 2'b11
    } mem_size_e;

    typedef struct packed {
        mem_op_e     op;
        mem_size_e   size;
        logic        sign;    // sign-extend narrow loads
        logic [31:0] addr;
        logic [31:0] wdata;   // right-aligned store data
    } lsu_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } lsu_rsp_t;

    localparam logic [31:0] SRAM_WORDS = bus_pkg::SRAM_BYTES / 4;

endpackage

//--- logic/bus_pkg.sv
package bus_pkg;

    // only the two codes the fabric can produce
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_decerr = 2'b11
    } bus_resp_e;

    typedef struct packed {
        logic [31:0] addr;
    } ar_chan_t;

    typedef struct packed {
        logic [31:0] data;
        bus_resp_e   resp;
    } r_chan_t;

    typedef struct packed {
        logic [31:0] addr;
    } aw_chan_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;   // one bit per byte lane
    } w_chan_t;

    typedef struct packed {
        bus_resp_e resp;
    } b_chan_t;

    // address map
    localparam logic [31:0] SRAM_BASE  = 32'h8000_0000;
    localparam logic [31:0] SRAM_BYTES = 32'd4096;

    // serial port, tx data at +0, sent-byte count at +4
    localparam logic [31:0] UART_BASE  = 32'ha000_03f8;
    localparam logic [31:0] UART_BYTES = 32'd8;

endpackage
